/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mips_core
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f src.f
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    localparam int xlen = 32;

    // opcodes
    localparam logic [5:0] op_rtype = 6'b000000;
    localparam logic [5:0] op_addiu = 6'b001001;
    localparam logic [5:0] op_lui   = 6'b001111;
    localparam logic [5:0] op_lw    = 6'b100011;
    localparam logic [5:0] op_sw    = 6'b101011;
    localparam logic [5:0] op_beq   = 6'b000100;
    localparam logic [5:0] op_bne   = 6'b000101;
    localparam logic [5:0] op_jal   = 6'b000011;

    // R-type function codes
    localparam logic [5:0] fn_sll  = 6'b000000;
    localparam logic [5:0] fn_srl  = 6'b000010;
    localparam logic [5:0] fn_sra  = 6'b000011;
    localparam logic [5:0] fn_jr   = 6'b001000;
    localparam logic [5:0] fn_addu = 6'b100001;
    localparam logic [5:0] fn_subu = 6'b100011;
    localparam logic [5:0] fn_and  = 6'b100100;
    localparam logic [5:0] fn_or   = 6'b100101;
    localparam logic [5:0] fn_xor  = 6'b100110;
    localparam logic [5:0] fn_nor  = 6'b100111;
    localparam logic [5:0] fn_slt  = 6'b101010;
    localparam logic [5:0] fn_sltu = 6'b101011;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] func;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_fields_t;

    typedef union packed {
        r_fields_t r;
        i_fields_t i; // jal index is the low 26 bits
    } instr_u;

    // bit positions in the one-hot alu op
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_sll  = 4;
    localparam int alu_srl  = 5;
    localparam int alu_sra  = 6;
    localparam int alu_lui  = 7;
    localparam int alu_or   = 8;
    localparam int alu_xor  = 9;
    localparam int alu_and  = 10;
    localparam int alu_nor  = 11;

    typedef logic [11:0] alu_op_t;

    typedef enum logic [1:0] {a_pc, a_rs, a_rt} a_sel_t;
    typedef enum logic [1:0] {b_rt, b_imm, b_eight, b_shamt} b_sel_t;
    typedef enum logic [1:0] {dst_rd, dst_rt, dst_r31} dst_sel_t;
    typedef enum logic {wb_alu, wb_mem} wb_sel_t;
    typedef enum logic [1:0] {pc_next, pc_branch, pc_jal, pc_jr} pc_sel_t;

    typedef struct packed {
        alu_op_t  alu_op;
        a_sel_t   a_sel;
        b_sel_t   b_sel;
        logic     reg_write;
        dst_sel_t dst_sel;
        wb_sel_t  wb_sel;
        logic     mem_write;
    } ctrl_t;

endpackage

`default_nettype wire

/* rtl/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  mips_pkg::ctrl_t           ctrl,
    input  logic [mips_pkg::xlen-1:0] pc,
    input  mips_pkg::instr_u          instr,
    input  logic [mips_pkg::xlen-1:0] rs_data,
    input  logic [mips_pkg::xlen-1:0] rt_data,
    output logic [mips_pkg::xlen-1:0] result
);

    logic [mips_pkg::xlen-1:0] a;
    logic [mips_pkg::xlen-1:0] b;
    logic [mips_pkg::xlen-1:0] sra_val;
    logic                      lt_signed;
    logic                      lt_unsigned;

    always_comb begin
        case (ctrl.a_sel)
            mips_pkg::a_pc: a = pc;
            mips_pkg::a_rt: a = rt_data;
            default:        a = rs_data;
        endcase

        case (ctrl.b_sel)
            mips_pkg::b_imm:   b = {{16{instr.i.imm16[15]}}, instr.i.imm16};
            mips_pkg::b_eight: b = 32'd8;
            mips_pkg::b_shamt: b = {27'd0, instr.r.shamt};
            default:           b = rt_data;
        endcase
    end

    assign sra_val     = $signed(a) >>> b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    // only one op bit is set, so the terms just OR together
    always_comb begin
        result = '0;
        if (ctrl.alu_op[mips_pkg::alu_add])  result = result | (a + b);
        if (ctrl.alu_op[mips_pkg::alu_sub])  result = result | (a - b);
        if (ctrl.alu_op[mips_pkg::alu_slt])  result = result | {31'd0, lt_signed};
        if (ctrl.alu_op[mips_pkg::alu_sltu]) result = result | {31'd0, lt_unsigned};
        if (ctrl.alu_op[mips_pkg::alu_sll])  result = result | (a << b[4:0]);
        if (ctrl.alu_op[mips_pkg::alu_srl])  result = result | (a >> b[4:0]);
        if (ctrl.alu_op[mips_pkg::alu_sra])  result = result | sra_val;
        if (ctrl.alu_op[mips_pkg::alu_lui])  result = result | {b[15:0], 16'd0};
        if (ctrl.alu_op[mips_pkg::alu_or])   result = result | (a | b);
        if (ctrl.alu_op[mips_pkg::alu_xor])  result = result | (a ^ b);
        if (ctrl.alu_op[mips_pkg::alu_and])  result = result | (a & b);
        if (ctrl.alu_op[mips_pkg::alu_nor])  result = result | ~(a | b);
    end

endmodule

`default_nettype wire

/* rtl/control.sv */
`timescale 1ns/1ps
`default_nettype none

module control (
    input  mips_pkg::instr_u  instr,
    input  logic              instr_valid,
    input  logic              is_eq,
    output mips_pkg::ctrl_t   ctrl,
    output mips_pkg::pc_sel_t pc_sel
);

    wire [5:0] opcode = instr.r.opcode;
    wire [5:0] func   = instr.r.func;

    wire is_rtype = opcode == mips_pkg::op_rtype;
    wire is_addiu = opcode == mips_pkg::op_addiu;
    wire is_lui   = opcode == mips_pkg::op_lui;
    wire is_lw    = opcode == mips_pkg::op_lw;
    wire is_sw    = opcode == mips_pkg::op_sw;
    wire is_beq   = opcode == mips_pkg::op_beq;
    wire is_bne   = opcode == mips_pkg::op_bne;
    wire is_jal   = opcode == mips_pkg::op_jal;

    wire r_sll  = is_rtype & (func == mips_pkg::fn_sll);
    wire r_srl  = is_rtype & (func == mips_pkg::fn_srl);
    wire r_sra  = is_rtype & (func == mips_pkg::fn_sra);
    wire r_jr   = is_rtype & (func == mips_pkg::fn_jr);
    wire r_addu = is_rtype & (func == mips_pkg::fn_addu);
    wire r_subu = is_rtype & (func == mips_pkg::fn_subu);
    wire r_and  = is_rtype & (func == mips_pkg::fn_and);
    wire r_or   = is_rtype & (func == mips_pkg::fn_or);
    wire r_xor  = is_rtype & (func == mips_pkg::fn_xor);
    wire r_nor  = is_rtype & (func == mips_pkg::fn_nor);
    wire r_slt  = is_rtype & (func == mips_pkg::fn_slt);
    wire r_sltu = is_rtype & (func == mips_pkg::fn_sltu);

    wire is_shift = r_sll | r_srl | r_sra;
    wire is_alu_r = is_shift | r_addu | r_subu | r_and | r_or | r_xor | r_nor
                  | r_slt | r_sltu; // jr and unknown funcs write nothing
    wire uses_imm = is_addiu | is_lw | is_sw | is_lui;

    wire take_branch = (is_beq & is_eq) | (is_bne & ~is_eq);

    always_comb begin
        ctrl.alu_op                     = '0;
        ctrl.alu_op[mips_pkg::alu_add]  = r_addu | is_addiu | is_lw | is_sw | is_jal;
        ctrl.alu_op[mips_pkg::alu_sub]  = r_subu;
        ctrl.alu_op[mips_pkg::alu_slt]  = r_slt;
        ctrl.alu_op[mips_pkg::alu_sltu] = r_sltu;
        ctrl.alu_op[mips_pkg::alu_sll]  = r_sll;
        ctrl.alu_op[mips_pkg::alu_srl]  = r_srl;
        ctrl.alu_op[mips_pkg::alu_sra]  = r_sra;
        ctrl.alu_op[mips_pkg::alu_lui]  = is_lui;
        ctrl.alu_op[mips_pkg::alu_or]   = r_or;
        ctrl.alu_op[mips_pkg::alu_xor]  = r_xor;
        ctrl.alu_op[mips_pkg::alu_and]  = r_and;
        ctrl.alu_op[mips_pkg::alu_nor]  = r_nor;

        if (is_jal) begin
            ctrl.a_sel = mips_pkg::a_pc;
        end else if (is_shift) begin
            ctrl.a_sel = mips_pkg::a_rt; // shifts operate on rt
        end else begin
            ctrl.a_sel = mips_pkg::a_rs;
        end

        if (is_jal) begin
            ctrl.b_sel = mips_pkg::b_eight; // link value is pc + 8
        end else if (is_shift) begin
            ctrl.b_sel = mips_pkg::b_shamt;
        end else if (uses_imm) begin
            ctrl.b_sel = mips_pkg::b_imm;
        end else begin
            ctrl.b_sel = mips_pkg::b_rt;
        end

        ctrl.reg_write = instr_valid & (is_alu_r | is_addiu | is_lw | is_lui | is_jal);
        ctrl.mem_write = instr_valid & is_sw;

        if (is_jal) begin
            ctrl.dst_sel = mips_pkg::dst_r31;
        end else if (is_rtype) begin
            ctrl.dst_sel = mips_pkg::dst_rd;
        end else begin
            ctrl.dst_sel = mips_pkg::dst_rt;
        end

        ctrl.wb_sel = is_lw ? mips_pkg::wb_mem : mips_pkg::wb_alu;

        if (!instr_valid) begin
            pc_sel = mips_pkg::pc_next; // hold off until fetch is valid
        end else if (take_branch) begin
            pc_sel = mips_pkg::pc_branch;
        end else if (is_jal) begin
            pc_sel = mips_pkg::pc_jal;
        end else if (r_jr) begin
            pc_sel = mips_pkg::pc_jr;
        end else begin
            pc_sel = mips_pkg::pc_next;
        end
    end

endmodule

`default_nettype wire

/* rtl/mips_core.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_core (
    input  logic                      clk,
    input  logic                      rst,
    output logic [mips_pkg::xlen-1:0] imem_addr,
    input  logic [31:0]               instr,
    input  logic                      instr_valid,
    output logic [mips_pkg::xlen-1:0] dmem_addr,
    output logic [mips_pkg::xlen-1:0] dmem_wdata,
    output logic [3:0]                dmem_wen,
    input  logic [mips_pkg::xlen-1:0] dmem_rdata
);

    mips_pkg::instr_u          instr_w;
    mips_pkg::ctrl_t           ctrl;
    mips_pkg::pc_sel_t         pc_sel;
    logic                      is_eq;
    logic [mips_pkg::xlen-1:0] pc;
    logic [mips_pkg::xlen-1:0] rs_data;
    logic [mips_pkg::xlen-1:0] rt_data;
    logic [mips_pkg::xlen-1:0] alu_result;

    assign instr_w    = instr;
    assign imem_addr  = pc;
    assign dmem_addr  = alu_result;
    assign dmem_wdata = rt_data;
    assign dmem_wen   = {4{ctrl.mem_write}}; // word stores only

    control u_control (
        .instr       (instr_w),
        .instr_valid (instr_valid),
        .is_eq       (is_eq),
        .ctrl        (ctrl),
        .pc_sel      (pc_sel)
    );

    alu u_alu (
        .ctrl    (ctrl),
        .pc      (pc),
        .instr   (instr_w),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .result  (alu_result)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .rst        (rst),
        .instr      (instr_w),
        .ctrl       (ctrl),
        .alu_result (alu_result),
        .mem_rdata  (dmem_rdata),
        .rs_data    (rs_data),
        .rt_data    (rt_data)
    );

    next_pc u_next_pc (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr_w),
        .pc_sel      (pc_sel),
        .instr_valid (instr_valid),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .pc          (pc),
        .is_eq       (is_eq)
    );

endmodule

`default_nettype wire

/* rtl/next_pc.sv */
`timescale 1ns/1ps
`default_nettype none

module next_pc (
    input  logic                      clk,
    input  logic                      rst,
    input  mips_pkg::instr_u          instr,
    input  mips_pkg::pc_sel_t         pc_sel,
    input  logic                      instr_valid,
    input  logic [mips_pkg::xlen-1:0] rs_data,
    input  logic [mips_pkg::xlen-1:0] rt_data,
    output logic [mips_pkg::xlen-1:0] pc,
    output logic                      is_eq
);

    logic [mips_pkg::xlen-1:0] pc_plus4;
    logic [mips_pkg::xlen-1:0] branch_target;
    logic [mips_pkg::xlen-1:0] jal_target;
    logic [mips_pkg::xlen-1:0] pc_nxt;

    assign is_eq         = rs_data == rt_data;
    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc_plus4 + {{14{instr.i.imm16[15]}}, instr.i.imm16, 2'b00};
    assign jal_target    = {pc_plus4[31:28], instr.i[25:0], 2'b00};

    always_comb begin
        case (pc_sel)
            mips_pkg::pc_branch: pc_nxt = branch_target;
            mips_pkg::pc_jal:    pc_nxt = jal_target;
            mips_pkg::pc_jr:     pc_nxt = rs_data;
            default:             pc_nxt = pc_plus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (instr_valid) begin // stalled fetch holds the pc
            pc <= pc_nxt;
        end
    end

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                      clk,
    input  logic                      rst,
    input  mips_pkg::instr_u          instr,
    input  mips_pkg::ctrl_t           ctrl,
    input  logic [mips_pkg::xlen-1:0] alu_result,
    input  logic [mips_pkg::xlen-1:0] mem_rdata,
    output logic [mips_pkg::xlen-1:0] rs_data,
    output logic [mips_pkg::xlen-1:0] rt_data
);

    logic [mips_pkg::xlen-1:0] regs [32];
    logic [4:0]                dst;
    logic [mips_pkg::xlen-1:0] wb_data;

    always_comb begin
        case (ctrl.dst_sel)
            mips_pkg::dst_rd:  dst = instr.r.rd;
            mips_pkg::dst_r31: dst = 5'd31;
            default:           dst = instr.r.rt;
        endcase
    end

    assign wb_data = (ctrl.wb_sel == mips_pkg::wb_mem) ? mem_rdata : alu_result;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.reg_write && dst != 5'd0) begin // r0 stays zero
            regs[dst] <= wb_data;
        end
    end

    assign rs_data = regs[instr.r.rs];
    assign rt_data = regs[instr.r.rt];

endmodule

`default_nettype wire

/* src.f */
+incdir+test
common/mips_pkg.sv
rtl/control.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/next_pc.sv
rtl/mips_core.sv
test/tb_mips_core.sv

/* test/tb_programs.svh */
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// operands of the arithmetic program
localparam logic [31:0] c1 = 32'h12345678;
localparam logic [31:0] c2 = 32'hf0f00ff0;
localparam logic [31:0] halt = 32'h1000ffff; // beq r0, r0, -1 spins in place

function automatic logic [31:0] ienc(logic [5:0] op, int rs, int rt, logic [15:0] imm);
    return {op, rs[4:0], rt[4:0], imm};
endfunction

function automatic logic [31:0] renc(int rs, int rt, int rd, int sh, logic [5:0] fn);
    return {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
endfunction

function automatic logic [31:0] jenc(int idx);
    return {6'h03, idx[25:0]}; // jal
endfunction

// fills instruction memory and the expected store list for one program
task automatic load_program(input int n);
    logic [31:0] prog [$];
    case (n)
        1: begin // arithmetic and logic on c1 and c2
            prog = '{ienc(6'h0f, 0, 1, 16'h1234), ienc(6'h09, 1, 1, 16'h5678),
                     ienc(6'h0f, 0, 2, 16'hf0f0), ienc(6'h09, 2, 2, 16'h0ff0),
                     renc(1, 2, 3, 0, 6'h21), ienc(6'h2b, 0, 3, 16'h0100),  // addu
                     renc(1, 2, 3, 0, 6'h23), ienc(6'h2b, 0, 3, 16'h0104),  // subu
                     renc(1, 2, 3, 0, 6'h24), ienc(6'h2b, 0, 3, 16'h0108),  // and
                     renc(1, 2, 3, 0, 6'h25), ienc(6'h2b, 0, 3, 16'h010c),  // or
                     renc(1, 2, 3, 0, 6'h26), ienc(6'h2b, 0, 3, 16'h0110),  // xor
                     renc(1, 2, 3, 0, 6'h27), ienc(6'h2b, 0, 3, 16'h0114),  // nor
                     halt};
            exp_addr = '{32'h100, 32'h104, 32'h108, 32'h10c, 32'h110, 32'h114};
            exp_data = '{c1 + c2, c1 - c2, c1 & c2, c1 | c2, c1 ^ c2, ~(c1 | c2)};
        end
        2: begin // compare and shift on a negative value
            prog = '{ienc(6'h0f, 0, 1, 16'h8765), ienc(6'h09, 1, 1, 16'h4321),
                     ienc(6'h09, 0, 2, 16'h0005),
                     renc(1, 2, 3, 0, 6'h2a), ienc(6'h2b, 0, 3, 16'h0100),  // slt
                     renc(1, 2, 3, 0, 6'h2b), ienc(6'h2b, 0, 3, 16'h0104),  // sltu
                     renc(0, 1, 3, 4, 6'h00), ienc(6'h2b, 0, 3, 16'h0108),  // sll
                     renc(0, 1, 3, 4, 6'h02), ienc(6'h2b, 0, 3, 16'h010c),  // srl
                     renc(0, 1, 3, 4, 6'h03), ienc(6'h2b, 0, 3, 16'h0110),  // sra
                     halt};
            exp_addr = '{32'h100, 32'h104, 32'h108, 32'h10c, 32'h110};
            exp_data = '{32'd1, 32'd0, 32'h76543210, 32'h08765432, 32'hf8765432};
        end
        3: begin // store, load back, then a write to r0
            prog = '{ienc(6'h0f, 0, 1, 16'hdead), ienc(6'h09, 1, 1, 16'hbeef),
                     ienc(6'h2b, 0, 1, 16'h0200), ienc(6'h23, 0, 4, 16'h0200),
                     ienc(6'h2b, 0, 4, 16'h0204), ienc(6'h09, 0, 0, 16'h0055),
                     ienc(6'h2b, 0, 0, 16'h0208), halt};
            exp_addr = '{32'h200, 32'h204, 32'h208};
            // addiu sign-extends the low half
            exp_data = '{32'hdead0000 + 32'hffffbeef, 32'hdead0000 + 32'hffffbeef, 32'd0};
        end
        4: begin // beq taken, bne not taken, jal and jr
            prog = '{ienc(6'h09, 0, 1, 16'h0007), ienc(6'h09, 0, 2, 16'h0007),
                     ienc(6'h04, 1, 2, 16'h0001), ienc(6'h2b, 0, 1, 16'h0300),
                     ienc(6'h2b, 0, 1, 16'h0304), ienc(6'h05, 1, 2, 16'h0001),
                     ienc(6'h2b, 0, 2, 16'h0308), jenc(11),
                     ienc(6'h2b, 0, 1, 16'h030c), ienc(6'h2b, 0, 31, 16'h0314),
                     halt, ienc(6'h2b, 0, 1, 16'h0310),
                     renc(31, 0, 0, 0, 6'h08)};
            exp_addr = '{32'h304, 32'h308, 32'h310, 32'h314};
            exp_data = '{32'd7, 32'd7, 32'd7, 32'h1c + 32'd8}; // link is jal address + 8
        end
        default: begin
            $display("no program with number %0d", n);
            n_fail++;
        end
    endcase
    for (int k = 0; k < prog.size(); k++) begin
        imem[k[5:0]] = prog[k];
    end
endtask

`endif

/* test/tb_mips_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;

    localparam int max_cycles = 200;

    logic        clk;
    logic        rst = 1'b1;
    logic        instr_valid = 1'b0;
    logic [31:0] imem_addr;
    logic [31:0] instr;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic [3:0]  dmem_wen;
    logic [31:0] dmem_rdata;

    logic [31:0] imem [64];
    logic [31:0] dmem [256];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    string       test_name;
    bit          run = 1'b0;
    bit          random_stall = 1'b0;
    integer      seed = 84764;
    int          n_stores;
    int          test_errors;
    int          n_pass;
    int          n_fail;

    `include "tb_programs.svh"

    mips_core uut (
        .clk         (clk),
        .rst         (rst),
        .imem_addr   (imem_addr),
        .instr       (instr),
        .instr_valid (instr_valid),
        .dmem_addr   (dmem_addr),
        .dmem_wdata  (dmem_wdata),
        .dmem_wen    (dmem_wen),
        .dmem_rdata  (dmem_rdata)
    );

    assign instr      = imem[imem_addr[7:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // fetch is valid every cycle, or about three in four when stalling
    always @(posedge clk) begin
        instr_valid <= run && (!random_stall || (($random(seed) & 3) != 0));
    end

    always @(posedge clk) begin : scoreboard
        int errs;
        errs = 0;
        if (rst) begin
            n_stores    <= 0;
            test_errors <= 0;
        end else begin
            assert (dmem_wen == 4'h0 || (dmem_wen == 4'hf && instr_valid)) else begin
                $display("%s: write enable %b seen with instr_valid %b",
                         test_name, dmem_wen, instr_valid);
                errs++;
            end
            if (instr_valid) begin
                assert (imem_addr[31:8] == '0 && imem_addr[1:0] == 2'b00) else begin
                    $display("%s: fetch from %h outside the program memory",
                             test_name, imem_addr);
                    errs++;
                end
            end
            if (dmem_wen != 4'h0) begin
                dmem[dmem_addr[9:2]] <= dmem_wdata;
                assert (n_stores < exp_addr.size()) else begin
                    $display("%s: unexpected extra store to %h", test_name, dmem_addr);
                    errs++;
                end
                if (n_stores < exp_addr.size()) begin
                    assert (dmem_addr == exp_addr[n_stores]) else begin
                        $display("MISMATCH %s store %0d address: expected %h actual %h",
                                 test_name, n_stores, exp_addr[n_stores], dmem_addr);
                        errs++;
                    end
                    assert (dmem_wdata == exp_data[n_stores]) else begin
                        $display("MISMATCH %s store %0d data: expected %h actual %h",
                                 test_name, n_stores, exp_data[n_stores], dmem_wdata);
                        errs++;
                    end
                end
                n_stores <= n_stores + 1;
            end
            test_errors <= test_errors + errs;
        end
    end

    task automatic run_test(input string name, input int prog, input bit stall);
        int cycles;
        test_name    = name;
        random_stall = stall;
        @(posedge clk);
        rst <= 1'b1;
        load_program(prog);
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        run <= 1'b1;
        cycles = 0;
        while (n_stores < exp_addr.size() && cycles < max_cycles) begin
            @(negedge clk);
            cycles++;
        end
        repeat (8) @(negedge clk); // room for a stray store after the last one
        run <= 1'b0;
        repeat (2) @(negedge clk);
        if (n_stores < exp_addr.size()) begin
            $display("%s: timed out after %0d cycles with %0d of %0d stores seen",
                     name, cycles, n_stores, exp_addr.size());
            n_fail++;
        end else if (test_errors != 0) begin
            $display("%s: failed with %0d errors", name, test_errors);
            n_fail++;
        end else begin
            $display("%s: passed, %0d stores checked", name, n_stores);
            n_pass++;
        end
    endtask

    initial begin
        n_pass = 0;
        n_fail = 0;
        run_test("arith_logic", 1, 1'b0);
        run_test("compare_shift", 2, 1'b0);
        run_test("memory", 3, 1'b0);
        run_test("control_flow", 4, 1'b0);
        run_test("backpressure", 1, 1'b1); // same stores as arith_logic
        $display("tests passed %0d failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
